// ==== logic/pic_pkg.sv ====
package pic_pkg;

   //////////////////////////////////////////////////
   // Sizes
   //////////////////////////////////////////////////
   localparam int NUM_SRC   = 32;   // Slot 0 is reserved
   localparam int IDX_BITS  = 5;
   localparam int ID_BITS   = 8;
   localparam int PRIO_BITS = 4;
   localparam int PRIO_MAX  = 15;

   //////////////////////////////////////////////////
   // Register map
   //////////////////////////////////////////////////
   localparam logic [31:0] PIC_BASE_ADDR = 32'hF00C_0000;
   localparam logic [31:0] PRIO_OFS      = 32'h0000_0000;
   localparam logic [31:0] PEND_OFS      = 32'h0000_1000;
   localparam logic [31:0] ENABLE_OFS    = 32'h0000_2000;
   localparam logic [31:0] CONFIG_OFS    = 32'h0000_3000;
   localparam logic [31:0] GW_CFG_OFS    = 32'h0000_4000;
   localparam logic [31:0] GW_CLR_OFS    = 32'h0000_5000;

   typedef enum logic [2:0] {
      REG_NONE,
      REG_PRIO,
      REG_PEND,
      REG_ENABLE,
      REG_CONFIG,
      REG_GW_CFG,
      REG_GW_CLR
   } pic_reg_kind_e;

   // One decoded register access
   typedef struct packed {
      pic_reg_kind_e       kind;
      logic [IDX_BITS-1:0] idx;    // Address bits 6:2
      logic [31:0]         data;
   } pic_reg_cmd_t;

   typedef struct packed {
      logic [PRIO_BITS-1:0] prio;
      logic                 enable;
      logic                 gw_type;       // Edge when set
      logic                 gw_polarity;   // Active low when set
   } pic_src_rd_t;

   typedef struct packed {
      logic [ID_BITS-1:0]   id;
      logic [PRIO_BITS-1:0] prio;   // Ordered priority, 0 when idle
   } pic_cand_t;

endpackage

// ==== logic/pic_gateway.sv ====
`timescale 1ns/1ps

module pic_gateway (
   input  logic clk,
   input  logic rst,
   input  logic req,
   input  logic polarity,
   input  logic edge_mode,
   input  logic clear,
   output logic pending
);

   logic [1:0] sync_q;    // Two-flop synchronizer
   logic       req_pol;
   logic       sticky_q;

   always_ff @(posedge clk) begin
      if (rst)
         sync_q <= '0;
      else
         sync_q <= {sync_q[0], req};
   end

   assign req_pol = sync_q[1] ^ polarity;

   // Edge capture holds until software clears it
   always_ff @(posedge clk) begin
      if (rst)
         sticky_q <= 1'b0;
      else
         sticky_q <= edge_mode && (req_pol || (sticky_q && !clear));
   end

   assign pending = edge_mode ? (req_pol | sticky_q) : req_pol;

   a_clear_wins: assert property (@(posedge clk) disable iff (rst)
      (clear && !req_pol) |=> !sticky_q)
      else $error("Gateway clear did not drop the captured request");

endmodule

// ==== logic/pic_reg_access.sv ====
`timescale 1ns/1ps

module pic_reg_access (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [31:0]                       picm_rdaddr,
   input  logic [31:0]                       picm_wraddr,
   input  logic [31:0]                       picm_wr_data,
   input  logic                              picm_wren,
   input  logic                              picm_rden,
   input  pic_pkg::pic_src_rd_t              src_rd,
   input  logic [pic_pkg::NUM_SRC-1:0]       pending,
   output pic_pkg::pic_reg_cmd_t             wr_cmd,
   output pic_pkg::pic_reg_cmd_t             rd_cmd,
   output logic                              intpriord,
   output logic [31:0]                       picm_rd_data
);

   logic        picm_wren_ff;
   logic        picm_rden_ff;
   logic [31:0] picm_raddr_ff;
   logic [31:0] picm_waddr_ff;
   logic [31:0] picm_wr_data_ff;
   logic [31:0] rd_data_in;
   logic        bypass;

   // Region match on everything above the word index
   function automatic logic region_hit(input logic [31:0] addr, input logic [31:0] ofs);
      logic [31:0] base;
      base = pic_pkg::PIC_BASE_ADDR + ofs;
      return addr[31:7] == base[31:7];
   endfunction

   function automatic pic_pkg::pic_reg_kind_e decode(input logic [31:0] addr);
      pic_pkg::pic_reg_kind_e kind;
      kind = pic_pkg::REG_NONE;
      if (region_hit(addr, pic_pkg::PRIO_OFS))
         kind = pic_pkg::REG_PRIO;
      else if (region_hit(addr, pic_pkg::ENABLE_OFS))
         kind = pic_pkg::REG_ENABLE;
      else if (region_hit(addr, pic_pkg::GW_CFG_OFS))
         kind = pic_pkg::REG_GW_CFG;
      else if (region_hit(addr, pic_pkg::GW_CLR_OFS))
         kind = pic_pkg::REG_GW_CLR;
      else if (addr == pic_pkg::PIC_BASE_ADDR + pic_pkg::PEND_OFS)
         kind = pic_pkg::REG_PEND;     // Single pending word
      else if (addr == pic_pkg::PIC_BASE_ADDR + pic_pkg::CONFIG_OFS)
         kind = pic_pkg::REG_CONFIG;
      return kind;
   endfunction

   //////////////////////////////////////////////////
   // Bus input flops
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         picm_wren_ff <= 1'b0;
         picm_rden_ff <= 1'b0;
      end else begin
         picm_wren_ff <= picm_wren;
         picm_rden_ff <= picm_rden;
      end
   end

   always_ff @(posedge clk) begin
      picm_raddr_ff   <= picm_rdaddr;
      picm_waddr_ff   <= picm_wraddr;
      picm_wr_data_ff <= picm_wr_data;
   end

   assign wr_cmd.kind = picm_wren_ff ? decode(picm_waddr_ff) : pic_pkg::REG_NONE;
   assign wr_cmd.idx  = picm_waddr_ff[6:2];
   assign wr_cmd.data = picm_wr_data_ff;

   assign rd_cmd.kind = picm_rden_ff ? decode(picm_raddr_ff) : pic_pkg::REG_NONE;
   assign rd_cmd.idx  = picm_raddr_ff[6:2];
   assign rd_cmd.data = '0;                  // Reads carry no data

   // Priority order bit, 1 lets lower values win
   always_ff @(posedge clk) begin
      if (rst)
         intpriord <= 1'b0;
      else if (wr_cmd.kind == pic_pkg::REG_CONFIG)
         intpriord <= wr_cmd.data[0];
   end

   //////////////////////////////////////////////////
   // Read data
   //////////////////////////////////////////////////
   always_comb begin
      case (rd_cmd.kind)
         pic_pkg::REG_PRIO:   rd_data_in = {{(32-pic_pkg::PRIO_BITS){1'b0}}, src_rd.prio};
         pic_pkg::REG_ENABLE: rd_data_in = {31'b0, src_rd.enable};
         pic_pkg::REG_GW_CFG: rd_data_in = {30'b0, src_rd.gw_type, src_rd.gw_polarity};
         pic_pkg::REG_PEND:   rd_data_in = pending;
         pic_pkg::REG_CONFIG: rd_data_in = {31'b0, intpriord};
         default:             rd_data_in = '0;   // Gateway clear is write only
      endcase
   end

   // Same-address read and write in one cycle returns the write data
   assign bypass       = picm_rden_ff && picm_wren_ff && (picm_raddr_ff == picm_waddr_ff);
   assign picm_rd_data = bypass ? picm_wr_data_ff : rd_data_in;

   a_rd_mapped: assert property (@(posedge clk) disable iff (rst)
      (picm_rden && decode(picm_rdaddr) != pic_pkg::REG_NONE)
         |=> rd_cmd.kind != pic_pkg::REG_NONE)
      else $error("Mapped read lost its command");

   // Slot 0 state lives in the bank and must stay zero
   a_idx0_zero: assert property (@(posedge clk) disable iff (rst)
      (rd_cmd.idx == '0 && (rd_cmd.kind == pic_pkg::REG_PRIO ||
                            rd_cmd.kind == pic_pkg::REG_ENABLE ||
                            rd_cmd.kind == pic_pkg::REG_GW_CFG))
         |-> src_rd == '0)
      else $error("Source 0 holds state");

endmodule

// ==== logic/pic_source_bank.sv ====
`timescale 1ns/1ps

module pic_source_bank (
   input  logic                                      clk,
   input  logic                                      rst,
   input  logic                                      intpriord,
   input  logic [pic_pkg::NUM_SRC-1:0]               extintsrc_req,
   input  pic_pkg::pic_reg_cmd_t                     wr_cmd,
   input  pic_pkg::pic_reg_cmd_t                     rd_cmd,
   output pic_pkg::pic_src_rd_t                      src_rd,
   output logic [pic_pkg::NUM_SRC-1:0]               pending,
   output pic_pkg::pic_cand_t [pic_pkg::NUM_SRC-1:0] cand
);

   pic_pkg::pic_src_rd_t [pic_pkg::NUM_SRC-1:0] src_all;   // Read-back of every slot

   // Slot 0 is reserved and never interrupts
   assign src_all[0] = '0;
   assign pending[0] = 1'b0;
   assign cand[0]    = '0;

   //////////////////////////////////////////////////
   // Per-source registers and gateways
   //////////////////////////////////////////////////
   for (genvar i = 1; i < pic_pkg::NUM_SRC; i++) begin : g_src
      logic [pic_pkg::PRIO_BITS-1:0] prio_q;
      logic [pic_pkg::PRIO_BITS-1:0] prio_ord;
      logic                          en_q;
      logic [1:0]                    gw_cfg_q;   // {edge, polarity}
      logic                          hit;
      logic                          gw_clr;

      assign hit    = (wr_cmd.idx == pic_pkg::IDX_BITS'(i));
      assign gw_clr = hit && (wr_cmd.kind == pic_pkg::REG_GW_CLR);   // One-cycle pulse

      always_ff @(posedge clk) begin
         if (rst) begin
            prio_q   <= '0;
            en_q     <= 1'b0;
            gw_cfg_q <= '0;
         end else if (hit) begin
            case (wr_cmd.kind)
               pic_pkg::REG_PRIO:   prio_q   <= wr_cmd.data[pic_pkg::PRIO_BITS-1:0];
               pic_pkg::REG_ENABLE: en_q     <= wr_cmd.data[0];
               pic_pkg::REG_GW_CFG: gw_cfg_q <= wr_cmd.data[1:0];
               default: ;
            endcase
         end
      end

      pic_gateway u_gw (
         .clk       (clk),
         .rst       (rst),
         .req       (extintsrc_req[i]),
         .polarity  (gw_cfg_q[0]),
         .edge_mode (gw_cfg_q[1]),
         .clear     (gw_clr),
         .pending   (pending[i])
      );

      // Reversed order flips the stored value so the tree always picks the max
      assign prio_ord = intpriord ? ~prio_q : prio_q;

      assign cand[i].id   = pic_pkg::ID_BITS'(i);
      assign cand[i].prio = (pending[i] && en_q) ? prio_ord : '0;

      assign src_all[i].prio        = prio_q;
      assign src_all[i].enable      = en_q;
      assign src_all[i].gw_type     = gw_cfg_q[1];
      assign src_all[i].gw_polarity = gw_cfg_q[0];
   end

   assign src_rd = src_all[rd_cmd.idx];

endmodule

// ==== logic/pic_priority_tree.sv ====
`timescale 1ns/1ps

module pic_priority_tree (
   input  pic_pkg::pic_cand_t [pic_pkg::NUM_SRC-1:0] cand,
   output pic_pkg::pic_cand_t                        winner
);

   // Heap layout, node k has children 2k and 2k+1, leaves at 32..63
   pic_pkg::pic_cand_t node [1:2*pic_pkg::NUM_SRC-1];

   for (genvar i = 0; i < pic_pkg::NUM_SRC; i++) begin : g_leaf
      assign node[pic_pkg::NUM_SRC+i] = cand[i];
   end

   //////////////////////////////////////////////////
   // Compare and select, root level first
   //////////////////////////////////////////////////
   for (genvar l = 0; l < 5; l++) begin : g_level
      for (genvar n = 0; n < (1 << l); n++) begin : g_node
         localparam int K = (1 << l) + n;

         // Left child covers the lower ids and keeps ties
         assign node[K] = (node[2*K+1].prio > node[2*K].prio) ? node[2*K+1] : node[2*K];
      end
   end

   assign winner = node[1];

endmodule

// ==== logic/pic_claim.sv ====
`timescale 1ns/1ps

module pic_claim (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          intpriord,
   input  pic_pkg::pic_cand_t            winner,
   input  logic [pic_pkg::PRIO_BITS-1:0] meicurpl,
   input  logic [pic_pkg::PRIO_BITS-1:0] meipt,
   output logic [pic_pkg::ID_BITS-1:0]   claimid,
   output logic [pic_pkg::PRIO_BITS-1:0] pl,
   output logic                          mexintpend,
   output logic                          mhwakeup
);

   logic [pic_pkg::PRIO_BITS-1:0] meipt_ord;
   logic [pic_pkg::PRIO_BITS-1:0] meicurpl_ord;
   logic [pic_pkg::PRIO_BITS-1:0] pl_in;
   logic [pic_pkg::PRIO_BITS-1:0] max_pl;
   logic                          mexintpend_in;
   logic                          mhwakeup_in;

   // Thresholds go through the same ordering as the sources
   assign meipt_ord    = intpriord ? ~meipt : meipt;
   assign meicurpl_ord = intpriord ? ~meicurpl : meicurpl;

   assign mexintpend_in = (winner.prio > meipt_ord) && (winner.prio > meicurpl_ord);

   assign pl_in       = intpriord ? ~winner.prio : winner.prio;   // Back to stored value
   assign max_pl      = intpriord ? '0 : pic_pkg::PRIO_BITS'(pic_pkg::PRIO_MAX);
   assign mhwakeup_in = (pl_in == max_pl);

   always_ff @(posedge clk) begin
      if (rst) begin
         claimid    <= '0;
         pl         <= '0;
         mexintpend <= 1'b0;
         mhwakeup   <= 1'b0;
      end else begin
         claimid    <= winner.id;
         pl         <= pl_in;
         mexintpend <= mexintpend_in;
         mhwakeup   <= mhwakeup_in;
      end
   end

   a_claim_valid: assert property (@(posedge clk) disable iff (rst)
      mexintpend |-> claimid != '0)
      else $error("Interrupt raised for reserved id 0");

endmodule

// ==== logic/pic_ctrl.sv ====
`timescale 1ns/1ps

module pic_ctrl (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [pic_pkg::NUM_SRC-1:0]       extintsrc_req,   // Bit 0 unused
   input  logic [31:0]                       picm_rdaddr,
   input  logic [31:0]                       picm_wraddr,
   input  logic [31:0]                       picm_wr_data,
   input  logic                              picm_wren,
   input  logic                              picm_rden,
   input  logic [pic_pkg::PRIO_BITS-1:0]     meicurpl,        // Current level
   input  logic [pic_pkg::PRIO_BITS-1:0]     meipt,           // Threshold
   output logic                              mexintpend,
   output logic [pic_pkg::ID_BITS-1:0]       claimid,
   output logic [pic_pkg::PRIO_BITS-1:0]     pl,
   output logic [31:0]                       picm_rd_data,
   output logic                              mhwakeup
);

   pic_pkg::pic_reg_cmd_t                      wr_cmd;
   pic_pkg::pic_reg_cmd_t                      rd_cmd;
   pic_pkg::pic_src_rd_t                       src_rd;
   pic_pkg::pic_cand_t [pic_pkg::NUM_SRC-1:0]  cand;
   pic_pkg::pic_cand_t                         winner;
   logic [pic_pkg::NUM_SRC-1:0]                pending;
   logic                                       intpriord;

   pic_reg_access u_reg_access (
      .clk          (clk),
      .rst          (rst),
      .picm_rdaddr  (picm_rdaddr),
      .picm_wraddr  (picm_wraddr),
      .picm_wr_data (picm_wr_data),
      .picm_wren    (picm_wren),
      .picm_rden    (picm_rden),
      .src_rd       (src_rd),
      .pending      (pending),
      .wr_cmd       (wr_cmd),
      .rd_cmd       (rd_cmd),
      .intpriord    (intpriord),
      .picm_rd_data (picm_rd_data)
   );

   pic_source_bank u_source_bank (
      .clk           (clk),
      .rst           (rst),
      .intpriord     (intpriord),
      .extintsrc_req (extintsrc_req),
      .wr_cmd        (wr_cmd),
      .rd_cmd        (rd_cmd),
      .src_rd        (src_rd),
      .pending       (pending),
      .cand          (cand)
   );

   pic_priority_tree u_priority_tree (
      .cand   (cand),
      .winner (winner)
   );

   pic_claim u_claim (
      .clk        (clk),
      .rst        (rst),
      .intpriord  (intpriord),
      .winner     (winner),
      .meicurpl   (meicurpl),
      .meipt      (meipt),
      .claimid    (claimid),
      .pl         (pl),
      .mexintpend (mexintpend),
      .mhwakeup   (mhwakeup)
   );

endmodule

// ==== include/pic_tb_ref.svh ====
`ifndef PIC_TB_REF_SVH
`define PIC_TB_REF_SVH

// Expected values of the registered core outputs
typedef struct packed {
   logic [7:0] id;
   logic [3:0] pl;
   logic       mexintpend;
   logic       mhwakeup;
} exp_out_t;

function automatic void shadow_clear();
   for (int i = 0; i < pic_pkg::NUM_SRC; i++) begin
      sh_prio[i]   = '0;
      sh_en[i]     = 1'b0;
      sh_gw[i]     = '0;
      sh_sticky[i] = 1'b0;
   end
   sh_ord = 1'b0;
   sh_req = '0;
endfunction

// Offset of the 128-byte region that holds the address
function automatic logic [31:0] region_of(input logic [31:0] addr);
   return {addr[31:7], 7'b0} - pic_pkg::PIC_BASE_ADDR;
endfunction

function automatic logic active_in(input int i);
   return sh_req[i] ^ sh_gw[i][0];   // Polarity applied
endfunction

// Edge mode keeps an active input until cleared
function automatic void capture_edges();
   for (int i = 1; i < pic_pkg::NUM_SRC; i++)
      sh_sticky[i] = sh_gw[i][1] && (sh_sticky[i] || active_in(i));
endfunction

function automatic logic [31:0] pending_word();
   logic [31:0] p;
   p = '0;
   for (int i = 1; i < pic_pkg::NUM_SRC; i++)
      p[i] = active_in(i) || sh_sticky[i];
   return p;
endfunction

function automatic void shadow_write(input logic [31:0] addr, input logic [31:0] data);
   int idx;
   idx = int'(addr[6:2]);
   if (idx != 0) begin   // Slot 0 keeps no state
      case (region_of(addr))
         pic_pkg::PRIO_OFS:   sh_prio[idx] = data[3:0];
         pic_pkg::ENABLE_OFS: sh_en[idx] = data[0];
         pic_pkg::GW_CFG_OFS: sh_gw[idx] = data[1:0];
         pic_pkg::GW_CLR_OFS: sh_sticky[idx] = 1'b0;
         default: ;
      endcase
   end
   if (addr == pic_pkg::PIC_BASE_ADDR + pic_pkg::CONFIG_OFS)
      sh_ord = data[0];
   capture_edges();
endfunction

function automatic logic [31:0] ref_read(input logic [31:0] addr);
   logic [31:0] val;
   int          idx;
   idx = int'(addr[6:2]);
   val = '0;
   case (region_of(addr))
      pic_pkg::PRIO_OFS:   val = 32'(sh_prio[idx]);
      pic_pkg::ENABLE_OFS: val = 32'(sh_en[idx]);
      pic_pkg::GW_CFG_OFS: val = 32'(sh_gw[idx]);
      default: ;
   endcase
   if (addr == pic_pkg::PIC_BASE_ADDR + pic_pkg::PEND_OFS)
      val = pending_word();
   if (addr == pic_pkg::PIC_BASE_ADDR + pic_pkg::CONFIG_OFS)
      val = 32'(sh_ord);
   return val;
endfunction

// Rank of a level, higher rank wins in either order
function automatic int rank_of(input logic [3:0] v);
   return sh_ord ? pic_pkg::PRIO_MAX - int'(v) : int'(v);
endfunction

function automatic exp_out_t ref_outputs(input logic [3:0] thr, input logic [3:0] cur);
   exp_out_t    e;
   logic [31:0] p;
   int          best_id;
   int          best_rank;
   p         = pending_word();
   best_id   = 0;
   best_rank = 0;
   for (int i = 1; i < pic_pkg::NUM_SRC; i++) begin
      if (p[i] && sh_en[i] && rank_of(sh_prio[i]) > best_rank) begin   // Ties keep lower id
         best_id   = i;
         best_rank = rank_of(sh_prio[i]);
      end
   end
   e.id         = 8'(best_id);
   e.pl         = 4'(sh_ord ? pic_pkg::PRIO_MAX - best_rank : best_rank);
   e.mexintpend = (best_rank > rank_of(thr)) && (best_rank > rank_of(cur));
   e.mhwakeup   = sh_ord ? (e.pl == 4'd0) : (e.pl == 4'(pic_pkg::PRIO_MAX));
   return e;
endfunction

`endif

// ==== dv/pic_ctrl_tb.sv ====
`timescale 1ns/1ps

module pic_ctrl_tb;

   localparam int ROUNDS      = 6;
   localparam int NUM_TESTS   = 3 * ROUNDS + 4;
   localparam int WATCHDOG_NS = NUM_TESTS * 200 * 4;

   logic        clk = 1'b0;
   logic        rst;
   logic [31:0] extintsrc_req;
   logic [31:0] picm_rdaddr;
   logic [31:0] picm_wraddr;
   logic [31:0] picm_wr_data;
   logic        picm_wren;
   logic        picm_rden;
   logic [3:0]  meicurpl;
   logic [3:0]  meipt;
   logic        mexintpend;
   logic [7:0]  claimid;
   logic [3:0]  pl;
   logic [31:0] picm_rd_data;
   logic        mhwakeup;
   logic [31:0] cyc = '0;   // Rising edges seen

   // Shadow register state
   logic [3:0]  sh_prio   [pic_pkg::NUM_SRC];
   logic        sh_en     [pic_pkg::NUM_SRC];
   logic [1:0]  sh_gw     [pic_pkg::NUM_SRC];
   logic        sh_sticky [pic_pkg::NUM_SRC];
   logic        sh_ord;
   logic [31:0] sh_req;

   `include "pic_tb_ref.svh"

   typedef struct packed {
      logic [31:0] due;
      logic        is_read;
      logic [31:0] exp_rd;
      exp_out_t    exp_out;
   } check_t;

   check_t checks [$];

   pic_ctrl pic_ctrl_inst (.*);

   always #2 clk = ~clk;

   always @(posedge clk) cyc <= cyc + 1;

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got);
      stop_on_error($sformatf("Error at %0t ns: %s expected %0h, got %0h", $time, name, exp, got));
   endtask

   function automatic logic [31:0] reg_addr(input logic [31:0] ofs, input int idx);
      return pic_pkg::PIC_BASE_ADDR + ofs + 32'(idx * 4);
   endfunction

   task automatic push_check(input int lat, input logic is_read, input logic [31:0] exp_rd);
      check_t chk;
      chk.due     = cyc + 32'(lat);
      chk.is_read = is_read;
      chk.exp_rd  = exp_rd;
      chk.exp_out = ref_outputs(meipt, meicurpl);
      checks.push_back(chk);
   endtask

   ////////////////////////////////////////////////////
   // Bus and request drivers act on the falling edge
   ////////////////////////////////////////////////////
   task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
      picm_wren    = 1'b1;
      picm_wraddr  = addr;
      picm_wr_data = data;
      shadow_write(addr, data);
      @(negedge clk);
      picm_wren = 1'b0;
   endtask

   task automatic read_reg(input logic [31:0] addr);
      picm_rden   = 1'b1;
      picm_rdaddr = addr;
      push_check(1, 1'b1, ref_read(addr));   // Data shows in the next cycle
      @(negedge clk);
      picm_rden = 1'b0;
   endtask

   // Read sampled with the write returns the raw write data
   task automatic write_read_same(input logic [31:0] addr, input logic [31:0] data);
      picm_rden   = 1'b1;
      picm_rdaddr = addr;
      push_check(1, 1'b1, data);
      write_reg(addr, data);
      picm_rden = 1'b0;
   endtask

   task automatic drive_requests(input logic [31:0] req);
      extintsrc_req = req;
      sh_req        = req;
      capture_edges();
   endtask

   // Two sync flops plus the output flop
   task automatic settle();
      push_check(3, 1'b0, '0);
      repeat (4) @(negedge clk);
   endtask

   task automatic config_source(input int idx, input logic [3:0] prio, input logic en,
                                input logic [1:0] gw);
      write_reg(reg_addr(pic_pkg::PRIO_OFS, idx), 32'(prio));
      write_reg(reg_addr(pic_pkg::ENABLE_OFS, idx), 32'(en));
      write_reg(reg_addr(pic_pkg::GW_CFG_OFS, idx), 32'(gw));
   endtask

   task automatic clear_gateways();
      for (int i = 1; i < pic_pkg::NUM_SRC; i++)
         write_reg(reg_addr(pic_pkg::GW_CFG_OFS, i), '0);   // Level mode with active high input
   endtask

   task automatic arb_round();
      for (int i = 1; i < pic_pkg::NUM_SRC; i++) begin
         write_reg(reg_addr(pic_pkg::PRIO_OFS, i), $urandom());
         write_reg(reg_addr(pic_pkg::ENABLE_OFS, i), $urandom());
      end
      drive_requests($urandom());
      meipt    = 4'($urandom());
      meicurpl = 4'($urandom());
      settle();
      meipt    = 4'($urandom());   // New thresholds on the same winner
      meicurpl = 4'($urandom());
      settle();
      read_reg(reg_addr(pic_pkg::PEND_OFS, 0));
   endtask

   ////////////////////////////////////////////////////
   // Comparing process
   ////////////////////////////////////////////////////
   always @(negedge clk) begin : compare_outputs
      check_t chk;
      while (checks.size() > 0 && checks[0].due <= cyc) begin
         chk = checks.pop_front();
         assert (chk.due == cyc)
            else stop_on_error($sformatf("A check due at cycle %0d was missed", chk.due));
         if (chk.is_read) begin
            assert (picm_rd_data === chk.exp_rd)
               else value_error("picm_rd_data", chk.exp_rd, picm_rd_data);
         end else begin
            assert (claimid === chk.exp_out.id)
               else value_error("claimid", 32'(chk.exp_out.id), 32'(claimid));
            assert (pl === chk.exp_out.pl)
               else value_error("pl", 32'(chk.exp_out.pl), 32'(pl));
            assert (mexintpend === chk.exp_out.mexintpend)
               else value_error("mexintpend", 32'(chk.exp_out.mexintpend), 32'(mexintpend));
            assert (mhwakeup === chk.exp_out.mhwakeup)
               else value_error("mhwakeup", 32'(chk.exp_out.mhwakeup), 32'(mhwakeup));
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      stop_on_error("Timeout, the tests did not finish in the expected time");
   end

   initial begin : stimulus
      int          idx;
      logic [31:0] ofs;
      logic [31:0] data;
      void'($urandom(32'h78c18e27));
      rst           = 1'b1;
      extintsrc_req = '0;
      picm_rdaddr   = '0;
      picm_wraddr   = '0;
      picm_wr_data  = '0;
      picm_wren     = 1'b0;
      picm_rden     = 1'b0;
      meicurpl      = '0;
      meipt         = '0;
      shadow_clear();
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      push_check(1, 1'b1, '0);   // Read data idle after reset
      settle();
      read_reg(reg_addr(pic_pkg::PEND_OFS, 0));

      // Register readback including slot 0
      for (int k = 0; k < 24; k++) begin
         idx  = int'($urandom_range(31, 0));
         data = $urandom();
         case ($urandom_range(3, 0))
            0:       ofs = pic_pkg::PRIO_OFS;
            1:       ofs = pic_pkg::ENABLE_OFS;
            2:       ofs = pic_pkg::GW_CFG_OFS;
            default: ofs = pic_pkg::GW_CLR_OFS;
         endcase
         write_reg(reg_addr(ofs, idx), data);
         read_reg(reg_addr(ofs, idx));
         write_reg(reg_addr(ofs, 0), $urandom());
         read_reg(reg_addr(ofs, 0));
      end
      write_reg(reg_addr(pic_pkg::CONFIG_OFS, 0), $urandom());
      read_reg(reg_addr(pic_pkg::CONFIG_OFS, 0));
      write_reg(reg_addr(pic_pkg::CONFIG_OFS, 0), 32'h1);
      read_reg(reg_addr(pic_pkg::CONFIG_OFS, 0));

      // Read-during-write bypass
      for (int k = 0; k < 4; k++) begin
         idx = int'($urandom_range(31, 1));
         write_read_same(reg_addr(pic_pkg::PRIO_OFS, idx), $urandom());
         read_reg(reg_addr(pic_pkg::PRIO_OFS, idx));
      end
      write_read_same(reg_addr(pic_pkg::CONFIG_OFS, 0), 32'hFFFF_FFFE);
      read_reg(reg_addr(pic_pkg::CONFIG_OFS, 0));

      // Level arbitration in normal order
      clear_gateways();
      drive_requests('0);
      settle();
      for (int r = 0; r < ROUNDS; r++)
         arb_round();

      // Reversed order makes stored 0 the top level
      write_reg(reg_addr(pic_pkg::CONFIG_OFS, 0), 32'h1);
      for (int r = 0; r < ROUNDS; r++)
         arb_round();
      config_source(7, 4'd0, 1'b1, 2'b00);
      drive_requests(32'h0000_0080);
      settle();

      // Edge capture on source 5 and inverted level on source 12
      write_reg(reg_addr(pic_pkg::CONFIG_OFS, 0), '0);
      drive_requests('0);
      meipt    = 4'd2;
      meicurpl = 4'd3;
      config_source(5, 4'd9, 1'b1, 2'b10);
      config_source(12, 4'd4, 1'b1, 2'b01);
      settle();
      read_reg(reg_addr(pic_pkg::PEND_OFS, 0));
      drive_requests(32'h0000_0020);
      @(negedge clk);
      drive_requests('0);   // One-cycle pulse
      settle();
      settle();
      read_reg(reg_addr(pic_pkg::PEND_OFS, 0));
      write_reg(reg_addr(pic_pkg::GW_CLR_OFS, 5), '0);
      settle();
      read_reg(reg_addr(pic_pkg::PEND_OFS, 0));
      drive_requests(32'h0000_1000);
      settle();
      read_reg(reg_addr(pic_pkg::PEND_OFS, 0));

      // Wake-up in normal order
      clear_gateways();
      for (int r = 0; r < ROUNDS; r++)
         arb_round();
      config_source(3, 4'd15, 1'b1, 2'b00);
      drive_requests(32'h0000_0008);
      settle();

      repeat (4) @(negedge clk);
      if (checks.size() == 0) begin
         $display("Testbench passed");
         $finish;
      end else begin
         stop_on_error("Some scheduled checks never ran");
      end
   end

endmodule

// ==== filelist.f ====
+incdir+include
logic/pic_pkg.sv
logic/pic_gateway.sv
logic/pic_reg_access.sv
logic/pic_source_bank.sv
logic/pic_priority_tree.sv
logic/pic_claim.sv
logic/pic_ctrl.sv
dv/pic_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module pic_ctrl_tb -f filelist.f -o pic_sim &&
./obj_dir/pic_sim | grep "Testbench passed" &&
echo "Simulation PASS" ||
{ echo "Simulation FAIL"; exit 1; }
